//--- hdl/input_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "preproc_cfg.svh"

module input_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    soft_reset_i,
  input  preproc_pkg::chan_mask_t chan_en_i,
  input  logic                    idata_valid_i,
  input  preproc_pkg::chan_mask_t fifo_full_i,
  output logic                    idata_ready_o,
  output logic                    accept_o,
  output preproc_pkg::chan_mask_t active_chan_o,
  output preproc_pkg::chan_idx_t  active_idx_o,
  output logic                    last_in_frame_o
);

  import preproc_pkg::*;

  // Channels still waiting for a sample in this frame
  chan_mask_t pending_q;
  chan_mask_t pending_d;
  chan_mask_t remaining;

  // Lowest pending channel, one-hot
  assign active_chan_o = pending_q & (~pending_q + 1'b1);

  always_comb begin
    active_idx_o = '0;
    for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
      if (active_chan_o[i]) begin
        active_idx_o = chan_idx_t'(i);
      end
    end
  end

  // Stall while the active channel's FIFO is full
  assign idata_ready_o = idata_valid_i & (|active_chan_o) & ~|(fifo_full_i & active_chan_o);
  assign accept_o      = idata_valid_i & idata_ready_o;

  assign remaining       = pending_q ^ active_chan_o;
  assign last_in_frame_o = accept_o & (remaining == '0);

  always_comb begin
    pending_d = pending_q;
    if (soft_reset_i) begin
      pending_d = chan_en_i;
    end else if (accept_o) begin
      // Frame done, start again from the enables
      pending_d = last_in_frame_o ? chan_en_i : remaining;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/offset_removal.sv
`timescale 1ns/1ns
`default_nettype none

`include "preproc_cfg.svh"

module offset_removal (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    soft_reset_i,
  input  logic                    accept_i,
  input  preproc_pkg::chan_idx_t  active_idx_i,
  input  preproc_pkg::sample_t    idata_i,
  input  preproc_pkg::chan_mask_t offrem_en_i,
  input  preproc_pkg::alpha_t     alpha_i       [`PREPROC_NR_CHANNELS],
  input  preproc_pkg::shift_t     shl_i         [`PREPROC_NR_CHANNELS],
  input  preproc_pkg::shift_t     shr_i         [`PREPROC_NR_CHANNELS],
  input  preproc_pkg::sample_t    pre_offset_i  [`PREPROC_NR_CHANNELS],
  input  preproc_pkg::sample_t    post_offset_i [`PREPROC_NR_CHANNELS],
  output preproc_pkg::sample_t    sample_o
);

  import preproc_pkg::*;

  // Running mean per channel
  sample_t ema_q [`PREPROC_NR_CHANNELS];

  logic                                offrem_act;
  sample_t                             cond;
  sample_t                             centered;
  logic [`PREPROC_DATA_WIDTH-1:0]      post_sum;
  logic signed [`PREPROC_ALPHA_WIDTH+1:0] alpha_w;
  logic signed [`PREPROC_ALPHA_WIDTH+1:0] alpha_inv;
  ema_acc_t                            ema_acc;
  sample_t                             ema_new;

  assign offrem_act = offrem_en_i[active_idx_i];

  ////////////////////
  // Sample path
  ////////////////////

  // Input scaling and pre-offset, wraps at 16 bits
  assign cond = (idata_i << shl_i[active_idx_i]) + pre_offset_i[active_idx_i];

  // Subtract the mean seen before this sample
  assign centered = offrem_act ? cond - ema_q[active_idx_i] : cond;

  // Post-offset, then logical right shift
  assign post_sum = centered + post_offset_i[active_idx_i];
  assign sample_o = sample_t'(post_sum >> shr_i[active_idx_i]);

  ////////////////////
  // EMA update
  ////////////////////

  // Weights alpha and 256 - alpha, both non-negative
  assign alpha_w   = {2'b00, alpha_i[active_idx_i]};
  assign alpha_inv = {2'b01, {`PREPROC_ALPHA_WIDTH{1'b0}}} - alpha_w;

  assign ema_acc = ema_acc_t'(alpha_w) * ema_acc_t'(cond)
                 + ema_acc_t'(alpha_inv) * ema_acc_t'(ema_q[active_idx_i]);
  // Drop the weight scaling, keep the sign
  assign ema_new = sample_t'(ema_acc >>> `PREPROC_ALPHA_WIDTH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
        ema_q[i] <= '0;
      end
    end else if (soft_reset_i) begin
      for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
        ema_q[i] <= '0;
      end
    end else if (accept_i && offrem_act) begin
      ema_q[active_idx_i] <= ema_new;
    end
  end

endmodule

`default_nettype wire

//--- hdl/output_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "preproc_cfg.svh"

module output_buffer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    soft_reset_i,
  input  preproc_pkg::chan_mask_t chan_en_i,
  input  preproc_pkg::subsampl_t  subsampl_i,
  input  logic                    accept_i,
  input  preproc_pkg::chan_mask_t active_chan_i,
  input  logic                    last_in_frame_i,
  input  preproc_pkg::sample_t    sample_i,
  input  logic                    odata_switch_channel_i,
  input  logic                    odata_ack_sample_i,
  output preproc_pkg::chan_mask_t fifo_full_o,
  output preproc_pkg::sample_t    odata_o,
  output logic                    odata_valid_o
);

  import preproc_pkg::*;

  subsampl_t sub_cnt_q;

  // Circular FIFOs, one row per channel
  sample_t   fifo_mem [`PREPROC_NR_CHANNELS][`PREPROC_FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q [`PREPROC_NR_CHANNELS];
  fifo_ptr_t rd_ptr_q [`PREPROC_NR_CHANNELS];
  fifo_cnt_t fill_q   [`PREPROC_NR_CHANNELS];

  chan_mask_t push;
  chan_mask_t pop;
  chan_mask_t empty;

  // Output selection, remaining channels of the round
  chan_mask_t sel_q;
  chan_mask_t selected;
  chan_mask_t sel_rest;

  function automatic fifo_ptr_t ptr_next(fifo_ptr_t ptr);
    return (ptr == fifo_ptr_t'(`PREPROC_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // Subsampling
  ////////////////////

  // Counter steps once per completed frame
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sub_cnt_q <= '0;
    end else if (soft_reset_i) begin
      sub_cnt_q <= '0;
    end else if (accept_i && last_in_frame_i) begin
      sub_cnt_q <= (sub_cnt_q == subsampl_i) ? '0 : sub_cnt_q + 1'b1;
    end
  end

  // Only frames with a zero count are kept
  assign push = (accept_i && sub_cnt_q == '0) ? active_chan_i : '0;

  ////////////////////
  // Channel FIFOs
  ////////////////////

  for (genvar i = 0; i < `PREPROC_NR_CHANNELS; i++) begin : g_flags
    assign empty[i]       = (fill_q[i] == '0);
    assign fifo_full_o[i] = (fill_q[i] == fifo_cnt_t'(`PREPROC_FIFO_DEPTH));
    // Ack drains every enabled channel, empty ones ignore it
    assign pop[i]         = odata_ack_sample_i & chan_en_i[i] & ~empty[i];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
        wr_ptr_q[i] <= '0;
        rd_ptr_q[i] <= '0;
        fill_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
        if (soft_reset_i) begin
          wr_ptr_q[i] <= '0;
          rd_ptr_q[i] <= '0;
          fill_q[i]   <= '0;
        end else begin
          if (push[i]) begin
            wr_ptr_q[i] <= ptr_next(wr_ptr_q[i]);
          end
          if (pop[i]) begin
            rd_ptr_q[i] <= ptr_next(rd_ptr_q[i]);
          end
          fill_q[i] <= fill_q[i] + fifo_cnt_t'(push[i]) - fifo_cnt_t'(pop[i]);
        end
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
      if (push[i]) begin
        fifo_mem[i][wr_ptr_q[i]] <= sample_i;
      end
    end
  end

  ////////////////////
  // Output select
  ////////////////////

  // Lowest remaining channel is shown
  assign selected = sel_q & (~sel_q + 1'b1);
  assign sel_rest = sel_q ^ selected;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else if (soft_reset_i) begin
      sel_q <= chan_en_i;
    end else if (odata_switch_channel_i) begin
      sel_q <= (sel_rest == '0) ? chan_en_i : sel_rest;
    end
  end

  assign odata_valid_o = |(selected & ~empty);

  // Head of the selected FIFO
  always_comb begin
    odata_o = '0;
    for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
      if (selected[i]) begin
        odata_o = fifo_mem[i][rd_ptr_q[i]];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/preproc_cfg.svh
`ifndef PREPROC_CFG_SVH
`define PREPROC_CFG_SVH

// Number of time-multiplexed input channels
`define PREPROC_NR_CHANNELS 4

// Signed sample width on the data path
`define PREPROC_DATA_WIDTH 16

// EMA weight, scaled by 2**PREPROC_ALPHA_WIDTH
`define PREPROC_ALPHA_WIDTH 8

// Shift amounts for input and output scaling
`define PREPROC_SHIFT_WIDTH 4

// Entries in each per-channel output FIFO
`define PREPROC_FIFO_DEPTH 4

// Subsampling counter and register
`define PREPROC_SUBSAMPL_WIDTH 16

// Config bus
`define PREPROC_ADDR_WIDTH 12
`define PREPROC_WORD_WIDTH 32

`endif

//--- hdl/preproc_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "preproc_cfg.svh"

module preproc_cfg_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Config bus
  input  logic                       cfg_req_i,
  input  logic                       cfg_we_i,
  input  preproc_reg_pkg::addr_t     cfg_addr_i,
  input  preproc_reg_pkg::word_t     cfg_wdata_i,
  output logic                       cfg_gnt_o,
  output preproc_reg_pkg::word_t     cfg_rdata_o,
  output logic                       cfg_rvalid_o,
  output logic                       soft_reset_o,
  // Per-channel configuration
  output preproc_pkg::chan_mask_t    chan_en_o,
  output preproc_pkg::chan_mask_t    offrem_en_o,
  output preproc_pkg::alpha_t        alpha_o       [`PREPROC_NR_CHANNELS],
  output preproc_pkg::shift_t        shl_o         [`PREPROC_NR_CHANNELS],
  output preproc_pkg::shift_t        shr_o         [`PREPROC_NR_CHANNELS],
  output preproc_pkg::sample_t       pre_offset_o  [`PREPROC_NR_CHANNELS],
  output preproc_pkg::sample_t       post_offset_o [`PREPROC_NR_CHANNELS],
  output preproc_pkg::subsampl_t     subsampl_o
);

  import preproc_pkg::*;
  import preproc_reg_pkg::*;

  logic [CFG_WORD_BITS-1:0] chan_cfg_q [`PREPROC_NR_CHANNELS];
  sample_t                  pre_offset_q  [`PREPROC_NR_CHANNELS];
  sample_t                  post_offset_q [`PREPROC_NR_CHANNELS];
  subsampl_t                subsampl_q;

  reg_bank_e bank;
  chan_idx_t chan_idx;
  logic      write_en;
  logic      read_en;
  word_t     rdata_d;
  word_t     rdata_q;
  logic      rvalid_q;

  // Every request is granted at once
  assign cfg_gnt_o = cfg_req_i;
  assign write_en  = cfg_req_i & cfg_we_i;
  assign read_en   = cfg_req_i & ~cfg_we_i;

  ////////////////////
  // Address decode
  ////////////////////

  always_comb begin
    bank     = BANK_NONE;
    chan_idx = cfg_addr_i[3:2];
    // Channel banks only map indices below the channel count
    if (cfg_addr_i[7:2] < `PREPROC_NR_CHANNELS) begin
      if (cfg_addr_i[11:8] == REG_CHAN_CFG_BASE[11:8]) begin
        bank = BANK_CHAN_CFG;
      end else if (cfg_addr_i[11:8] == REG_PRE_OFFSET_BASE[11:8]) begin
        bank = BANK_PRE_OFFSET;
      end else if (cfg_addr_i[11:8] == REG_POST_OFFSET_BASE[11:8]) begin
        bank = BANK_POST_OFFSET;
      end
    end
    // Global registers need an exact match
    if (cfg_addr_i == REG_SUBSAMPLING || cfg_addr_i == REG_SOFT_RESET) begin
      bank = BANK_GLOBAL;
    end
  end

  ////////////////////
  // Register writes
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PREPROC_NR_CHANNELS; i++) begin
        chan_cfg_q[i]    <= '0;
        pre_offset_q[i]  <= '0;
        post_offset_q[i] <= '0;
      end
      subsampl_q <= '0;
    end else if (write_en) begin
      case (bank)
        BANK_CHAN_CFG:    chan_cfg_q[chan_idx]    <= cfg_wdata_i[CFG_WORD_BITS-1:0];
        BANK_PRE_OFFSET:  pre_offset_q[chan_idx]  <= cfg_wdata_i[`PREPROC_DATA_WIDTH-1:0];
        BANK_POST_OFFSET: post_offset_q[chan_idx] <= cfg_wdata_i[`PREPROC_DATA_WIDTH-1:0];
        BANK_GLOBAL: begin
          if (cfg_addr_i == REG_SUBSAMPLING) begin
            subsampl_q <= cfg_wdata_i[`PREPROC_SUBSAMPL_WIDTH-1:0];
          end
        end
        // Unmapped, write dropped
        default: ;
      endcase
    end
  end

  // Strobe in the request cycle, state clears at the next edge
  assign soft_reset_o = write_en & (cfg_addr_i == REG_SOFT_RESET);

  ////////////////////
  // Read-back
  ////////////////////

  always_comb begin
    rdata_d = '0;
    case (bank)
      BANK_CHAN_CFG:    rdata_d[CFG_WORD_BITS-1:0] = chan_cfg_q[chan_idx];
      BANK_PRE_OFFSET:  rdata_d[`PREPROC_DATA_WIDTH-1:0] = pre_offset_q[chan_idx];
      BANK_POST_OFFSET: rdata_d[`PREPROC_DATA_WIDTH-1:0] = post_offset_q[chan_idx];
      BANK_GLOBAL: begin
        // Soft reset address reads as zero
        if (cfg_addr_i == REG_SUBSAMPLING) begin
          rdata_d[`PREPROC_SUBSAMPL_WIDTH-1:0] = subsampl_q;
        end
      end
      default: rdata_d = ILLEGAL_READ_DATA;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= read_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rdata_o  = rdata_q;
  assign cfg_rvalid_o = rvalid_q;

  // Split the config words into their fields
  for (genvar i = 0; i < `PREPROC_NR_CHANNELS; i++) begin : g_fields
    assign chan_en_o[i]     = chan_cfg_q[i][CFG_CHAN_EN_BIT];
    assign offrem_en_o[i]   = chan_cfg_q[i][CFG_OFFREM_EN_BIT];
    assign alpha_o[i]       = chan_cfg_q[i][CFG_ALPHA_LSB +: `PREPROC_ALPHA_WIDTH];
    assign shl_o[i]         = chan_cfg_q[i][CFG_SHL_LSB +: `PREPROC_SHIFT_WIDTH];
    assign shr_o[i]         = chan_cfg_q[i][CFG_SHR_LSB +: `PREPROC_SHIFT_WIDTH];
    assign pre_offset_o[i]  = pre_offset_q[i];
    assign post_offset_o[i] = post_offset_q[i];
  end

  assign subsampl_o = subsampl_q;

endmodule

`default_nettype wire

//--- hdl/preproc_pkg.sv
`default_nettype none

`include "preproc_cfg.svh"

package preproc_pkg;

  // Data path sample, two's complement
  typedef logic signed [`PREPROC_DATA_WIDTH-1:0] sample_t;
  typedef logic [`PREPROC_ALPHA_WIDTH-1:0] alpha_t;
  typedef logic [`PREPROC_SHIFT_WIDTH-1:0] shift_t;

  // One bit per channel, bit i is channel i
  typedef logic [`PREPROC_NR_CHANNELS-1:0] chan_mask_t;
  typedef logic [$clog2(`PREPROC_NR_CHANNELS)-1:0] chan_idx_t;

  // Frames to drop between kept frames
  typedef logic [`PREPROC_SUBSAMPL_WIDTH-1:0] subsampl_t;

  // FIFO addressing and fill level (0 .. depth)
  typedef logic [$clog2(`PREPROC_FIFO_DEPTH)-1:0] fifo_ptr_t;
  typedef logic [$clog2(`PREPROC_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // EMA sum of two weighted samples, with sign headroom
  typedef logic signed [`PREPROC_DATA_WIDTH+`PREPROC_ALPHA_WIDTH+1:0] ema_acc_t;

endpackage

`default_nettype wire

//--- hdl/preproc_reg_pkg.sv
`default_nettype none

`include "preproc_cfg.svh"

package preproc_reg_pkg;

  typedef logic [`PREPROC_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`PREPROC_WORD_WIDTH-1:0] word_t;

  // Per-channel banks, channel index in addr[3:2]
  localparam addr_t REG_CHAN_CFG_BASE    = 'h000;
  localparam addr_t REG_PRE_OFFSET_BASE  = 'h100;
  localparam addr_t REG_POST_OFFSET_BASE = 'h200;

  // Global registers
  localparam addr_t REG_SUBSAMPLING = 'h300;
  localparam addr_t REG_SOFT_RESET  = 'h304;

  // Channel config word layout
  localparam int unsigned CFG_CHAN_EN_BIT   = 0;
  localparam int unsigned CFG_OFFREM_EN_BIT = 1;
  localparam int unsigned CFG_ALPHA_LSB     = 2;
  localparam int unsigned CFG_SHL_LSB       = 10;
  localparam int unsigned CFG_SHR_LSB       = 14;
  // Stored bits of a config word, upper bits read as zero
  localparam int unsigned CFG_WORD_BITS     = CFG_SHR_LSB + `PREPROC_SHIFT_WIDTH;

  // Returned for reads of unmapped addresses
  localparam word_t ILLEGAL_READ_DATA = 32'hDEADDA7A;

  typedef enum logic [2:0] {
    BANK_CHAN_CFG,
    BANK_PRE_OFFSET,
    BANK_POST_OFFSET,
    BANK_GLOBAL,
    BANK_NONE
  } reg_bank_e;

endpackage

`default_nettype wire

//--- hdl/preproc_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "preproc_cfg.svh"

module preproc_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Config bus
  input  logic                   cfg_req_i,
  output logic                   cfg_gnt_o,
  input  logic                   cfg_we_i,
  input  preproc_reg_pkg::addr_t cfg_addr_i,
  input  preproc_reg_pkg::word_t cfg_wdata_i,
  output preproc_reg_pkg::word_t cfg_rdata_o,
  output logic                   cfg_rvalid_o,
  // Input stream
  input  preproc_pkg::sample_t   idata_i,
  input  logic                   idata_valid_i,
  output logic                   idata_ready_o,
  // Output side
  output preproc_pkg::sample_t   odata_o,
  output logic                   odata_valid_o,
  input  logic                   odata_switch_channel_i,
  input  logic                   odata_ack_sample_i
);

  import preproc_pkg::*;

  // Configuration
  chan_mask_t chan_en;
  chan_mask_t offrem_en;
  alpha_t     alpha       [`PREPROC_NR_CHANNELS];
  shift_t     shl         [`PREPROC_NR_CHANNELS];
  shift_t     shr         [`PREPROC_NR_CHANNELS];
  sample_t    pre_offset  [`PREPROC_NR_CHANNELS];
  sample_t    post_offset [`PREPROC_NR_CHANNELS];
  subsampl_t  subsampl;
  logic       soft_reset;

  // Sequencing and data
  chan_mask_t fifo_full;
  chan_mask_t active_chan;
  chan_idx_t  active_idx;
  logic       accept;
  logic       last_in_frame;
  sample_t    proc_sample;

  preproc_cfg_regs i_cfg_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_req_i     (cfg_req_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_gnt_o     (cfg_gnt_o),
    .cfg_rdata_o   (cfg_rdata_o),
    .cfg_rvalid_o  (cfg_rvalid_o),
    .soft_reset_o  (soft_reset),
    .chan_en_o     (chan_en),
    .offrem_en_o   (offrem_en),
    .alpha_o       (alpha),
    .shl_o         (shl),
    .shr_o         (shr),
    .pre_offset_o  (pre_offset),
    .post_offset_o (post_offset),
    .subsampl_o    (subsampl)
  );

  input_sequencer i_input_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .soft_reset_i    (soft_reset),
    .chan_en_i       (chan_en),
    .idata_valid_i   (idata_valid_i),
    .fifo_full_i     (fifo_full),
    .idata_ready_o   (idata_ready_o),
    .accept_o        (accept),
    .active_chan_o   (active_chan),
    .active_idx_o    (active_idx),
    .last_in_frame_o (last_in_frame)
  );

  offset_removal i_offset_removal (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .soft_reset_i  (soft_reset),
    .accept_i      (accept),
    .active_idx_i  (active_idx),
    .idata_i       (idata_i),
    .offrem_en_i   (offrem_en),
    .alpha_i       (alpha),
    .shl_i         (shl),
    .shr_i         (shr),
    .pre_offset_i  (pre_offset),
    .post_offset_i (post_offset),
    .sample_o      (proc_sample)
  );

  output_buffer i_output_buffer (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .soft_reset_i           (soft_reset),
    .chan_en_i              (chan_en),
    .subsampl_i             (subsampl),
    .accept_i               (accept),
    .active_chan_i          (active_chan),
    .last_in_frame_i        (last_in_frame),
    .sample_i               (proc_sample),
    .odata_switch_channel_i (odata_switch_channel_i),
    .odata_ack_sample_i     (odata_ack_sample_i),
    .fifo_full_o            (fifo_full),
    .odata_o                (odata_o),
    .odata_valid_o          (odata_valid_o)
  );

endmodule

`default_nettype wire

//--- preproc_top.f
+incdir+hdl
hdl/preproc_pkg.sv
hdl/preproc_reg_pkg.sv
hdl/preproc_cfg_regs.sv
hdl/input_sequencer.sv
hdl/offset_removal.sv
hdl/output_buffer.sv
hdl/preproc_top.sv
tb/preproc_checker.sv
tb/preproc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the preprocessor testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timing -f preproc_top.f --top-module preproc_tb \
  -o Vpreproc_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vpreproc_tb > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
if [ $SIM_STATUS -ne 0 ]; then
  echo "Simulation exited with status $SIM_STATUS"
  exit 1
fi
exit 0

//--- tb/preproc_checker.sv
`timescale 1ns/1ns
`default_nettype none

module preproc_checker (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 cfg_req_i,
  input logic                 cfg_we_i,
  input logic                 cfg_gnt_o,
  input logic                 cfg_rvalid_o,
  input logic                 idata_valid_i,
  input logic                 idata_ready_o,
  input preproc_pkg::sample_t odata_o,
  input logic                 odata_valid_o,
  input logic                 odata_switch_channel_i,
  input logic                 odata_ack_sample_i
);

  ////////////////////
  // Config bus
  ////////////////////

  // Grant in the request cycle
  gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_gnt_o == cfg_req_i)
    else $error("cfg_gnt_o differs from cfg_req_i");

  // Read data one cycle later
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_req_i && !cfg_we_i) |=> cfg_rvalid_o)
    else $error("cfg_rvalid_o missing after a read");

  // No rvalid without a read the cycle before
  rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_rvalid_o |-> $past(cfg_req_i && !cfg_we_i))
    else $error("cfg_rvalid_o without a read request");

  ////////////////////
  // Data handshakes
  ////////////////////

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idata_ready_o |-> idata_valid_i)
    else $error("idata_ready_o high without idata_valid_i");

  // Head holds until switch or ack
  odata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (odata_valid_o && !odata_switch_channel_i && !odata_ack_sample_i)
    |=> (!odata_valid_o || $stable(odata_o)))
    else $error("odata_o changed while valid");

endmodule

bind preproc_top preproc_checker checker_i (.*);

`default_nettype wire

//--- tb/preproc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "preproc_cfg.svh"

module preproc_tb;

  import preproc_pkg::*;
  import preproc_reg_pkg::*;

  localparam int NR = `PREPROC_NR_CHANNELS;

  logic    clk_i;
  logic    rst_ni;
  logic    cfg_req_i;
  logic    cfg_we_i;
  addr_t   cfg_addr_i;
  word_t   cfg_wdata_i;
  logic    cfg_gnt_o;
  word_t   cfg_rdata_o;
  logic    cfg_rvalid_o;
  sample_t idata_i;
  logic    idata_valid_i;
  logic    idata_ready_o;
  sample_t odata_o;
  logic    odata_valid_o;
  logic    odata_switch_channel_i;
  logic    odata_ack_sample_i;

  // Reference model state
  chan_mask_t m_en;
  chan_mask_t m_off;
  alpha_t     m_alpha [NR];
  shift_t     m_shl   [NR];
  shift_t     m_shr   [NR];
  sample_t    m_pre   [NR];
  sample_t    m_post  [NR];
  sample_t    m_ema   [NR];
  int         m_sub;
  int         m_sub_cnt;
  sample_t    exp_q   [NR][$];
  integer     seed;
  bit         run_passed;
  bit         fail_shown;

  preproc_top preproc_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic show_fail();
    if (!fail_shown) begin
      fail_shown = 1'b1;
      $display("Verification failed");
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%s", msg);
    show_fail();
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  ////////////////////
  // Config bus
  ////////////////////

  task automatic cfg_write(input addr_t addr, input word_t data);
    next_cycle();
    cfg_req_i   = 1'b1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    next_cycle();
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
  endtask

  task automatic cfg_read(input addr_t addr, input word_t exp);
    int t;
    next_cycle();
    cfg_req_i  = 1'b1;
    cfg_we_i   = 1'b0;
    cfg_addr_i = addr;
    next_cycle();
    cfg_req_i  = 1'b0;
    t = 0;
    while (!cfg_rvalid_o) begin
      if (t >= 4) report_fail("Timeout waiting for cfg_rvalid_o");
      next_cycle();
      t++;
    end
    assert (cfg_rdata_o == exp)
      else report_fail($sformatf("Error: cfg_rdata_o got 0x%h expected 0x%h at 0x%h",
                                 cfg_rdata_o, exp, addr));
  endtask

  task automatic set_chan(input int ch, input bit en, input bit off, input int alpha,
                          input int shl, input int shr, input sample_t pre,
                          input sample_t post);
    word_t w;
    w        = '0;
    w[0]     = en;
    w[1]     = off;
    w[9:2]   = alpha[7:0];
    w[13:10] = shl[3:0];
    w[17:14] = shr[3:0];
    cfg_write(REG_CHAN_CFG_BASE + addr_t'(ch * 4), w);
    cfg_write(REG_PRE_OFFSET_BASE + addr_t'(ch * 4), {16'h0, pre});
    cfg_write(REG_POST_OFFSET_BASE + addr_t'(ch * 4), {16'h0, post});
    m_en[ch]    = en;
    m_off[ch]   = off;
    m_alpha[ch] = alpha[7:0];
    m_shl[ch]   = shl[3:0];
    m_shr[ch]   = shr[3:0];
    m_pre[ch]   = pre;
    m_post[ch]  = post;
  endtask

  task automatic set_subsampling(input int value);
    cfg_write(REG_SUBSAMPLING, word_t'(value));
    m_sub = value;
  endtask

  // Clears EMA, FIFOs and frame counter, reloads masks
  task automatic soft_reset();
    cfg_write(REG_SOFT_RESET, '0);
    for (int i = 0; i < NR; i++) begin
      m_ema[i] = '0;
      exp_q[i].delete();
    end
    m_sub_cnt = 0;
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic sample_t stage(input int ch, input sample_t d);
    sample_t     x;
    sample_t     e;
    logic [15:0] r;
    integer      acc;
    x = sample_t'(d << m_shl[ch]) + m_pre[ch];
    e = m_off[ch] ? x - m_ema[ch] : x;
    r = $unsigned(sample_t'(e + m_post[ch])) >> m_shr[ch];
    if (m_off[ch]) begin
      acc = int'(m_alpha[ch]) * int'(x) + (256 - int'(m_alpha[ch])) * int'(m_ema[ch]);
      m_ema[ch] = sample_t'(acc >>> 8);
    end
    return sample_t'(r);
  endfunction

  ////////////////////
  // Data traffic
  ////////////////////

  task automatic send_sample(input sample_t d);
    int t;
    next_cycle();
    idata_i       = d;
    idata_valid_i = 1'b1;
    #1;
    t = 0;
    while (!idata_ready_o) begin
      if (t >= 100) report_fail("Timeout waiting for idata_ready_o");
      next_cycle();
      #1;
      t++;
    end
    next_cycle();
    idata_valid_i = 1'b0;
  endtask

  // One sample per enabled channel, lowest channel first
  task automatic send_frame();
    sample_t d;
    sample_t r;
    bit      keep;
    keep = (m_sub_cnt == 0);
    for (int ch = 0; ch < NR; ch++) begin
      if (m_en[ch]) begin
        d = sample_t'($random(seed));
        r = stage(ch, d);
        send_sample(d);
        if (keep) exp_q[ch].push_back(r);
      end
    end
    m_sub_cnt = (m_sub_cnt == m_sub) ? 0 : m_sub_cnt + 1;
  endtask

  task automatic wait_valid();
    int t;
    t = 0;
    while (!odata_valid_o) begin
      if (t >= 100) report_fail("Timeout waiting for odata_valid_o");
      next_cycle();
      t++;
    end
  endtask

  // Visit each enabled channel, ack on the last one
  task automatic read_channel();
    int      last;
    sample_t exp;
    last = 0;
    for (int ch = 0; ch < NR; ch++) begin
      if (m_en[ch]) last = ch;
    end
    for (int ch = 0; ch < NR; ch++) begin
      if (m_en[ch]) begin
        wait_valid();
        if (exp_q[ch].size() == 0) report_fail("Output shows a sample that was not expected");
        exp = exp_q[ch].pop_front();
        assert (odata_o == exp)
          else report_fail($sformatf("Error: odata_o got 0x%h expected 0x%h on channel %0d",
                                     odata_o, exp, ch));
        odata_switch_channel_i = 1'b1;
        odata_ack_sample_i     = (ch == last);
        next_cycle();
        odata_switch_channel_i = 1'b0;
        odata_ack_sample_i     = 1'b0;
      end
    end
  endtask

  task automatic ack_only();
    for (int ch = 0; ch < NR; ch++) begin
      if (m_en[ch] && exp_q[ch].size() != 0) void'(exp_q[ch].pop_front());
    end
    odata_ack_sample_i = 1'b1;
    next_cycle();
    odata_ack_sample_i = 1'b0;
  endtask

  // Valid held high, nothing may be accepted
  task automatic check_stall(input int cycles);
    idata_valid_i = 1'b1;
    for (int i = 0; i < cycles; i++) begin
      #1;
      assert (!idata_ready_o)
        else report_fail($sformatf("Error: idata_ready_o got 0x%h expected 0x0", idata_ready_o));
      next_cycle();
    end
    idata_valid_i = 1'b0;
  endtask

  initial begin
    #2_000_000;
    report_fail("Simulation did not finish in time");
  end

  final begin
    if (!run_passed) show_fail();
  end

  initial begin
    seed = 27;
    run_passed = 1'b0;
    fail_shown = 1'b0;
    rst_ni = 1'b0;
    cfg_req_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    idata_i = '0;
    idata_valid_i = 1'b0;
    odata_switch_channel_i = 1'b0;
    odata_ack_sample_i = 1'b0;
    m_en = '0;
    m_off = '0;
    m_sub = 0;
    m_sub_cnt = 0;
    for (int i = 0; i < NR; i++) begin
      m_alpha[i] = '0;
      m_shl[i] = '0;
      m_shr[i] = '0;
      m_pre[i] = '0;
      m_post[i] = '0;
      m_ema[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Quiet after reset, masks still empty
    assert (!idata_ready_o)
      else report_fail($sformatf("Error: idata_ready_o got 0x%h expected 0x0", idata_ready_o));
    assert (!odata_valid_o)
      else report_fail($sformatf("Error: odata_valid_o got 0x%h expected 0x0", odata_valid_o));
    assert (!cfg_rvalid_o)
      else report_fail($sformatf("Error: cfg_rvalid_o got 0x%h expected 0x0", cfg_rvalid_o));
    check_stall(4);

    // Register read-back
    cfg_write(REG_CHAN_CFG_BASE + 12'h00C, 32'hFFFF_FFFF);
    cfg_read(REG_CHAN_CFG_BASE + 12'h00C, 32'h0003_FFFF);
    cfg_write(REG_PRE_OFFSET_BASE + 12'h004, 32'h1234_ABCD);
    cfg_read(REG_PRE_OFFSET_BASE + 12'h004, 32'h0000_ABCD);
    cfg_write(REG_POST_OFFSET_BASE + 12'h008, 32'h5555_8001);
    cfg_read(REG_POST_OFFSET_BASE + 12'h008, 32'h0000_8001);
    cfg_write(REG_SUBSAMPLING, 32'hABCD_0005);
    cfg_read(REG_SUBSAMPLING, 32'h0000_0005);
    cfg_read(REG_SOFT_RESET, 32'h0);
    cfg_read(12'h310, ILLEGAL_READ_DATA);
    cfg_read(REG_CHAN_CFG_BASE + 12'h010, ILLEGAL_READ_DATA);

    // Two channels, plain scaling and offsets
    set_chan(0, 1, 0, 0, 2, 1, 16'h0010, 16'hFFF0);
    set_chan(1, 0, 0, 0, 0, 0, 16'h0000, 16'h0000);
    set_chan(2, 1, 0, 0, 0, 3, -16'sd5, 16'h0007);
    set_chan(3, 0, 0, 0, 0, 0, 16'h0000, 16'h0000);
    set_subsampling(0);
    soft_reset();
    repeat (4) send_frame();
    repeat (4) read_channel();

    // Offset removal on channel 1
    set_chan(1, 1, 1, 32, 0, 0, 16'h0000, 16'h0000);
    set_chan(2, 0, 0, 0, 0, 0, 16'h0000, 16'h0000);
    soft_reset();
    for (int r = 0; r < 3; r++) begin
      repeat (4) send_frame();
      repeat (4) read_channel();
    end

    // Keep one frame in three
    set_subsampling(2);
    soft_reset();
    repeat (10) send_frame();
    repeat (4) read_channel();

    // Back-pressure from full FIFOs
    set_subsampling(0);
    soft_reset();
    repeat (`PREPROC_FIFO_DEPTH) send_frame();
    check_stall(5);
    ack_only();
    send_frame();
    check_stall(5);
    repeat (`PREPROC_FIFO_DEPTH) read_channel();

    run_passed = 1'b1;
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
